/* verilog/rs_pkg.sv */
// reservation station shared definitions
// sizes, tag widths, function-unit kinds and row formats
package rs_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	// table rows
	localparam int rs_size = 8;
	// dispatch width, also the cdb lane count
	localparam int ss_size = 3;

	// issue ports, alu first, then mult, then memory
	localparam int alu_ports = 2;
	localparam int mult_ports = 1;
	localparam int mem_ports = 1;
	localparam int num_fu = alu_ports + mult_ports + mem_ports;

	// first port of each non-alu class
	localparam int port_mult = alu_ports;
	localparam int port_mem = alu_ports + mult_ports;

	// lsq busy level bits
	localparam int lsq_ld_bit = 0;
	localparam int lsq_st_bit = 1;

	//////////////////////////////////////////////////
	// field types
	//////////////////////////////////////////////////

	typedef logic [5:0] phys_reg_t;
	typedef logic [4:0] rob_idx_t;
	typedef logic [3:0] op_t;
	typedef logic [$clog2(rs_size)-1:0] row_idx_t;
	// 0 up to rs_size inclusive
	typedef logic [$clog2(rs_size+1)-1:0] row_cnt_t;
	// 0 up to ss_size inclusive
	typedef logic [$clog2(ss_size+1)-1:0] disp_cnt_t;

	// which unit class a row goes to
	typedef enum logic [1:0] {
		fu_alu,
		fu_mult,
		fu_ld,
		fu_st
	} fu_kind_t;

	// one waiting instruction, tags only
	typedef struct packed {
		logic valid;
		fu_kind_t fu;
		op_t op;
		phys_reg_t dest;
		phys_reg_t src1;
		phys_reg_t src2;
		logic src1_ready;
		logic src2_ready;
		rob_idx_t rob_idx;
	} rs_row_t;

	// one completion broadcast
	typedef struct packed {
		logic valid;
		phys_reg_t tag;
	} cdb_t;

endpackage

/* verilog/rs_cam.sv */
// tag match for one cdb lane
// compares the broadcast tag with both source tags of every row
`timescale 1ns/10ps

module rs_cam import rs_pkg::*; (
	input cdb_t cdb_lane,
	input phys_reg_t [rs_size-1:0] row_src1,
	input phys_reg_t [rs_size-1:0] row_src2,
	output logic [rs_size-1:0] hit1,
	output logic [rs_size-1:0] hit2
);

	// lane valid gates every compare
	logic lane_on;

	assign lane_on = cdb_lane.valid;

	always_comb begin
		hit1 = '0;
		hit2 = '0;
		// row valid is not looked at here
		// top masks empty rows itself
		for (int i = 0; i < rs_size; i++) begin
			hit1[i] = lane_on && (row_src1[i] == cdb_lane.tag);
			hit2[i] = lane_on && (row_src2[i] == cdb_lane.tag);
		end
	end

endmodule

/* verilog/rs_issue_select.sv */
// issue select for the reservation station
// oldest eligible rows go to the alu, mult and memory ports
`timescale 1ns/10ps

module rs_issue_select import rs_pkg::*; (
	input rs_row_t [rs_size-1:0] rs_table,
	input logic [1:0] lsq_busy,
	input logic enable,
	output logic [rs_size-1:0] issued_mask,
	output logic [num_fu-1:0] port_valid,
	output row_idx_t [num_fu-1:0] port_row
);

	// per row ready to go, before port limits
	logic [rs_size-1:0] eligible;

	//////////////////////////////////////////////////
	// eligibility
	//////////////////////////////////////////////////

	always_comb begin
		logic mem_ok;
		for (int i = 0; i < rs_size; i++) begin
			// loads and stores each see only their own queue
			mem_ok = 1'b1;
			if (rs_table[i].fu == fu_ld)
				mem_ok = !lsq_busy[lsq_ld_bit];
			if (rs_table[i].fu == fu_st)
				mem_ok = !lsq_busy[lsq_st_bit];
			eligible[i] = enable && rs_table[i].valid && rs_table[i].src1_ready &&
				rs_table[i].src2_ready && mem_ok;
		end
	end

	//////////////////////////////////////////////////
	// port assignment
	//////////////////////////////////////////////////

	// row 0 is oldest, so an upward scan is age order
	always_comb begin
		int alu_taken;
		int mult_taken;
		int mem_taken;
		issued_mask = '0;
		port_valid = '0;
		port_row = '0;
		alu_taken = 0;
		mult_taken = 0;
		mem_taken = 0;
		for (int i = 0; i < rs_size; i++) begin
			if (eligible[i]) begin
				case (rs_table[i].fu)
					fu_alu: begin
						// alu ports fill from port 0 up
						if (alu_taken < alu_ports) begin
							port_valid[alu_taken] = 1'b1;
							port_row[alu_taken] = row_idx_t'(i);
							issued_mask[i] = 1'b1;
							alu_taken++;
						end
					end
					fu_mult: begin
						if (mult_taken < mult_ports) begin
							port_valid[port_mult + mult_taken] = 1'b1;
							port_row[port_mult + mult_taken] = row_idx_t'(i);
							issued_mask[i] = 1'b1;
							mult_taken++;
						end
					end
					default: begin
						// loads and stores share the memory port
						if (mem_taken < mem_ports) begin
							port_valid[port_mem + mem_taken] = 1'b1;
							port_row[port_mem + mem_taken] = row_idx_t'(i);
							issued_mask[i] = 1'b1;
							mem_taken++;
						end
					end
				endcase
			end
		end
	end

	// every issued row owns exactly one port
	always_comb begin
		if (!$isunknown(issued_mask) && !$isunknown(port_valid))
			assert ($countones(issued_mask) == $countones(port_valid))
			else $error("issued rows and valid ports disagree");
	end

endmodule

/* verilog/rs_compactor.sv */
// table compaction for the reservation station
// drops issued rows in age order and appends dispatched rows at the end
`timescale 1ns/10ps

module rs_compactor import rs_pkg::*; (
	input rs_row_t [rs_size-1:0] rs_table,
	input row_cnt_t count,
	input logic [rs_size-1:0] issued_mask,
	input rs_row_t [ss_size-1:0] disp_rows,
	input disp_cnt_t disp_num,
	output rs_row_t [rs_size-1:0] next_table,
	output row_cnt_t next_count
);

	// rows that stay in the table
	logic [rs_size-1:0] survive;
	// survivors below each row, i.e. its new slot
	row_cnt_t [rs_size-1:0] new_slot;
	// total survivors, also the first append slot
	row_cnt_t surv_num;
	row_cnt_t issued_num;

	//////////////////////////////////////////////////
	// survivor positions
	//////////////////////////////////////////////////

	always_comb begin
		row_cnt_t below;
		below = '0;
		for (int i = 0; i < rs_size; i++) begin
			survive[i] = rs_table[i].valid && !issued_mask[i];
			new_slot[i] = below;
			if (survive[i])
				below = below + 1'b1;
		end
		surv_num = below;
	end

	assign issued_num = row_cnt_t'($countones(issued_mask));

	//////////////////////////////////////////////////
	// next table
	//////////////////////////////////////////////////

	always_comb begin
		next_table = '0;
		// shift down, order kept
		for (int i = 0; i < rs_size; i++) begin
			if (survive[i])
				next_table[row_idx_t'(new_slot[i])] = rs_table[i];
		end
		// append oldest dispatched row first
		// rows past the table end are dropped
		for (int k = 0; k < ss_size; k++) begin
			if ((k < int'(disp_num)) && ((int'(surv_num) + k) < rs_size))
				next_table[int'(surv_num) + k] = disp_rows[k];
		end
	end

	// occupancy after issue and dispatch
	assign next_count = count - issued_num + row_cnt_t'(disp_num);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	always_comb begin
		if (!$isunknown(count)) begin
			assert (count <= row_cnt_t'(rs_size))
			else $error("row count above table size");
		end
	end

	// table must stay packed below count
	always_comb begin
		if (!$isunknown(count)) begin
			for (int i = 0; i < rs_size; i++) begin
				if (i >= int'(count))
					assert (!rs_table[i].valid)
					else $error("valid row %0d at or above count", i);
			end
		end
	end

endmodule

/* verilog/reservation_station.sv */
// reservation station top
// tag table with cdb wakeup, oldest-first issue and dispatch credit
`timescale 1ns/10ps

module reservation_station import rs_pkg::*; (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic dispatch,
	input rs_row_t [ss_size-1:0] inst_in,
	input cdb_t [ss_size-1:0] cdb,
	input logic [1:0] lsq_busy,
	output rs_row_t [num_fu-1:0] inst_out,
	output logic [num_fu-1:0] issue,
	output disp_cnt_t num_can_dispatch
);

	// registered table, row 0 oldest
	rs_row_t [rs_size-1:0] table_q;
	row_cnt_t count_q;

	// table with this cycle's cdb applied
	rs_row_t [rs_size-1:0] woken_table;
	rs_row_t [rs_size-1:0] next_table;
	row_cnt_t next_count;

	// cam side
	phys_reg_t [rs_size-1:0] row_src1;
	phys_reg_t [rs_size-1:0] row_src2;
	logic [ss_size-1:0][rs_size-1:0] hit1_lane;
	logic [ss_size-1:0][rs_size-1:0] hit2_lane;
	logic [rs_size-1:0] hit1_any;
	logic [rs_size-1:0] hit2_any;

	// dispatch side
	logic disp_go;
	logic disp_contig;
	rs_row_t [ss_size-1:0] disp_rows;
	disp_cnt_t disp_num;

	// select results
	logic [rs_size-1:0] issued_mask;
	logic [num_fu-1:0] port_valid;
	row_idx_t [num_fu-1:0] port_row;

	// credit for the next cycle
	row_cnt_t free_next;
	disp_cnt_t credit_next;

	//////////////////////////////////////////////////
	// wakeup
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			row_src1[i] = table_q[i].src1;
			row_src2[i] = table_q[i].src2;
		end
	end

	// one cam per cdb lane
	for (genvar l = 0; l < ss_size; l++) begin : g_cam
		rs_cam u_cam (
			.cdb_lane(cdb[l]),
			.row_src1(row_src1),
			.row_src2(row_src2),
			.hit1(hit1_lane[l]),
			.hit2(hit2_lane[l])
		);
	end

	// merge lanes, empty rows never wake
	always_comb begin
		hit1_any = '0;
		hit2_any = '0;
		for (int l = 0; l < ss_size; l++) begin
			hit1_any = hit1_any | hit1_lane[l];
			hit2_any = hit2_any | hit2_lane[l];
		end
		woken_table = table_q;
		for (int i = 0; i < rs_size; i++) begin
			woken_table[i].src1_ready = table_q[i].src1_ready | (table_q[i].valid & hit1_any[i]);
			woken_table[i].src2_ready = table_q[i].src2_ready | (table_q[i].valid & hit2_any[i]);
		end
	end

	//////////////////////////////////////////////////
	// dispatch
	//////////////////////////////////////////////////

	assign disp_go = dispatch && enable;

	// incoming rows see the same broadcasts as the table
	always_comb begin
		disp_rows = '0;
		disp_num = '0;
		for (int k = 0; k < ss_size; k++) begin
			if (disp_go && inst_in[k].valid) begin
				disp_rows[k] = inst_in[k];
				disp_num = disp_num + 1'b1;
				for (int l = 0; l < ss_size; l++) begin
					if (cdb[l].valid && (cdb[l].tag == inst_in[k].src1))
						disp_rows[k].src1_ready = 1'b1;
					if (cdb[l].valid && (cdb[l].tag == inst_in[k].src2))
						disp_rows[k].src2_ready = 1'b1;
				end
			end
		end
	end

	// no hole below a valid row
	always_comb begin
		disp_contig = 1'b1;
		for (int k = 1; k < ss_size; k++) begin
			if (inst_in[k].valid && !inst_in[k-1].valid)
				disp_contig = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// select and compaction
	//////////////////////////////////////////////////

	rs_issue_select u_select (
		.rs_table(woken_table),
		.lsq_busy(lsq_busy),
		.enable(enable),
		.issued_mask(issued_mask),
		.port_valid(port_valid),
		.port_row(port_row)
	);

	rs_compactor u_compactor (
		.rs_table(woken_table),
		.count(count_q),
		.issued_mask(issued_mask),
		.disp_rows(disp_rows),
		.disp_num(disp_num),
		.next_table(next_table),
		.next_count(next_count)
	);

	// lesser of dispatch width and free rows
	assign free_next = row_cnt_t'(rs_size) - next_count;
	assign credit_next = (free_next < row_cnt_t'(ss_size)) ? disp_cnt_t'(free_next) :
		disp_cnt_t'(ss_size);

	always_ff @(posedge clock) begin
		if (reset) begin
			table_q <= '0;
			count_q <= '0;
			issue <= '0;
			inst_out <= '0;
			num_can_dispatch <= disp_cnt_t'(ss_size);
		end else begin
			table_q <= next_table;
			count_q <= next_count;
			// one cycle pulse per issued row
			issue <= port_valid;
			for (int p = 0; p < num_fu; p++)
				inst_out[p] <= port_valid[p] ? woken_table[port_row[p]] : '0;
			num_can_dispatch <= credit_next;
		end
	end

	// decoder stays within the credit it was given
	assert property (@(posedge clock) disable iff (reset) disp_num <= num_can_dispatch)
	else $error("dispatch above credit");

	assert property (@(posedge clock) disable iff (reset) disp_go |-> disp_contig)
	else $error("dispatched rows not contiguous from element 0");

endmodule

/* testbench/rs_clock_gen.sv */
// clock and reset source for the reservation station testbench
// 4 ns clock, reset held for the first 5 rising edges
`timescale 1ns/10ps

module rs_clock_gen (
	output logic clock,
	output logic reset
);

	// half of the 4 ns period
	localparam real half_period = 2.0;
	localparam int reset_cycles = 5;

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	// release lands on the edge after the last reset cycle
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

/* testbench/rs_tb.sv */
// reservation station testbench
// random and directed dispatch, cdb and stall traffic against a shadow age model
`timescale 1ns/10ps

module rs_tb import rs_pkg::*; ();

	localparam int rob_slots = 32;
	localparam int never_ready = 32'h7fffffff;
	localparam int random_cycles = 300;
	localparam int drain_limit = 64;
	localparam int wait_limit = 20;
	// every test with its drain and the reset plus slack
	localparam int watchdog_cycles = random_cycles + 6 * drain_limit + 10 * wait_limit + 64;

	logic clock;
	logic reset;
	logic enable;
	logic dispatch;
	rs_row_t [ss_size-1:0] inst_in;
	cdb_t [ss_size-1:0] cdb;
	logic [1:0] lsq_busy;
	rs_row_t [num_fu-1:0] inst_out;
	logic [num_fu-1:0] issue;
	disp_cnt_t num_can_dispatch;

	// what goes onto the inputs at the next edge
	rs_row_t [ss_size-1:0] nxt_rows;
	cdb_t [ss_size-1:0] nxt_cdb;
	logic nxt_dispatch;
	logic nxt_en;
	logic [1:0] nxt_lsq;
	int nxt_num;

	// shadow model with one slot per rob_idx
	bit in_flight [rob_slots];
	bit reserved [rob_slots];
	fu_kind_t kind_of [rob_slots];
	int order_of [rob_slots];
	int disp_cycle [rob_slots];
	int ready_cycle [rob_slots];
	int issue_cycle [rob_slots];
	bit pend1 [rob_slots];
	bit pend2 [rob_slots];
	phys_reg_t tag1 [rob_slots];
	phys_reg_t tag2 [rob_slots];

	// short history since outputs lag the select cycle by two edges
	bit en_hist [4];
	logic [1:0] lsq_hist [4];
	int disp_hist [4];

	int cyc;
	int occ;
	int order_ctr;
	int errors;
	int tests;
	int issued_total;
	logic [31:0] lfsr;
	phys_reg_t sweep_tag;

	rs_clock_gen clk_gen (
		.clock(clock),
		.reset(reset)
	);

	reservation_station uut (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.dispatch(dispatch),
		.inst_in(inst_in),
		.cdb(cdb),
		.lsq_busy(lsq_busy),
		.inst_out(inst_out),
		.issue(issue),
		.num_can_dispatch(num_can_dispatch)
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic void log_error(string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endfunction

	function automatic void note_failure(string msg);
		errors++;
		$display("%s", msg);
	endfunction

	// galois lfsr stepped once per bit handed out
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic int kind_class(fu_kind_t k);
		case (k)
			fu_alu: return 0;
			fu_mult: return 1;
			default: return 2;
		endcase
	endfunction

	function automatic int port_class(int p);
		if (p < port_mult)
			return 0;
		if (p < port_mem)
			return 1;
		return 2;
	endfunction

	// free rows the decoder may count on and never above the real credit
	function automatic int credit_now();
		return (rs_size - occ < ss_size) ? rs_size - occ : ss_size;
	endfunction

	// in the table with sources ready and its queue free during cycle s
	function automatic bit model_eligible(int r, int s, bit en, logic [1:0] lsq);
		bit mem_ok;
		mem_ok = !((kind_of[r] == fu_ld && lsq[lsq_ld_bit]) ||
			(kind_of[r] == fu_st && lsq[lsq_st_bit]));
		return en && disp_cycle[r] < s && ready_cycle[r] <= s && mem_ok;
	endfunction

	// offer one row next cycle and return its rob_idx
	// op and dest carry the rob slot too
	function automatic int queue_row(fu_kind_t kind, phys_reg_t t1, logic r1,
		phys_reg_t t2, logic r2);
		int r;
		r = 0;
		while ((in_flight[r] || reserved[r]) && r < rob_slots - 1)
			r++;
		reserved[r] = 1'b1;
		nxt_rows[nxt_num] = '{valid: 1'b1, fu: kind, op: op_t'(r), dest: phys_reg_t'(r),
			src1: t1, src2: t2, src1_ready: r1, src2_ready: r2, rob_idx: rob_idx_t'(r)};
		nxt_num++;
		nxt_dispatch = 1'b1;
		return r;
	endfunction

	//////////////////////////////////////////////////
	// model update and output checks
	//////////////////////////////////////////////////

	// accepted rows first and then the cdb which also wakes them
	function automatic void record_cycle();
		int h;
		int r;
		h = cyc & 3;
		en_hist[h] = nxt_en;
		lsq_hist[h] = nxt_lsq;
		disp_hist[h] = 0;
		for (int k = 0; k < ss_size; k++) begin
			if (nxt_rows[k].valid) begin
				r = int'(nxt_rows[k].rob_idx);
				reserved[r] = 1'b0;
				if (nxt_en && nxt_dispatch) begin
					in_flight[r] = 1'b1;
					kind_of[r] = nxt_rows[k].fu;
					order_of[r] = order_ctr;
					order_ctr++;
					disp_cycle[r] = cyc;
					pend1[r] = !nxt_rows[k].src1_ready;
					pend2[r] = !nxt_rows[k].src2_ready;
					tag1[r] = nxt_rows[k].src1;
					tag2[r] = nxt_rows[k].src2;
					ready_cycle[r] = (pend1[r] || pend2[r]) ? never_ready : cyc;
					occ++;
					disp_hist[h]++;
				end
			end
		end
		for (int l = 0; l < ss_size; l++) begin
			if (nxt_cdb[l].valid) begin
				for (int i = 0; i < rob_slots; i++) begin
					if (in_flight[i] && ready_cycle[i] == never_ready) begin
						if (pend1[i] && tag1[i] == nxt_cdb[l].tag)
							pend1[i] = 1'b0;
						if (pend2[i] && tag2[i] == nxt_cdb[l].tag)
							pend2[i] = 1'b0;
						if (!pend1[i] && !pend2[i])
							ready_cycle[i] = cyc;
					end
				end
			end
		end
	endfunction

	// outputs seen now were selected two cycles back
	function automatic void check_outputs();
		int s;
		int r;
		int exp_credit;
		bit en;
		logic [1:0] lsq;
		s = cyc - 2;
		en = en_hist[s & 3];
		lsq = lsq_hist[s & 3];
		if (!en)
			assert (issue == '0) else log_error("issue raised while enable was low");
		for (int p = 0; p < num_fu; p++) begin
			if (issue[p]) begin
				r = int'(inst_out[p].rob_idx);
				assert (in_flight[r])
				else log_error($sformatf("rob %0d on port %0d was not waiting", r, p));
				assert (kind_class(inst_out[p].fu) == port_class(p))
				else log_error($sformatf("port %0d carries the wrong unit kind", p));
				if (in_flight[r]) begin
					assert (inst_out[p].fu == kind_of[r])
					else log_error($sformatf("rob %0d came out with a different kind", r));
					assert (inst_out[p].valid && inst_out[p].src1_ready &&
						inst_out[p].src2_ready)
					else log_error($sformatf("rob %0d came out without valid and ready bits", r));
					assert (inst_out[p].src1 == tag1[r] && inst_out[p].src2 == tag2[r])
					else log_error($sformatf("rob %0d came out with wrong source tags", r));
					assert (inst_out[p].dest == phys_reg_t'(r) && inst_out[p].op == op_t'(r))
					else log_error($sformatf("rob %0d came out with wrong dest or op", r));
					assert (disp_cycle[r] < s && ready_cycle[r] <= s)
					else log_error($sformatf("rob %0d issued before its sources were ready", r));
					assert (!(kind_of[r] == fu_ld && lsq[lsq_ld_bit]))
					else log_error($sformatf("load rob %0d issued with load queue busy", r));
					assert (!(kind_of[r] == fu_st && lsq[lsq_st_bit]))
					else log_error($sformatf("store rob %0d issued with store queue busy", r));
					in_flight[r] = 1'b0;
					issue_cycle[r] = s;
					occ--;
					issued_total++;
				end
			end
		end
		// an older eligible row of the same class must not be left behind
		for (int p = 0; p < num_fu; p++) begin
			if (issue[p]) begin
				r = int'(inst_out[p].rob_idx);
				for (int o = 0; o < rob_slots; o++) begin
					if (in_flight[o] && kind_class(kind_of[o]) == port_class(p) &&
						order_of[o] < order_of[r])
						assert (!model_eligible(o, s, en, lsq))
						else log_error($sformatf("older rob %0d passed over by rob %0d", o, r));
				end
			end
		end
		// credit shown now counts dispatch up to the select cycle only
		exp_credit = rs_size - (occ - disp_hist[(cyc - 1) & 3]);
		if (exp_credit > ss_size)
			exp_credit = ss_size;
		assert (num_can_dispatch == disp_cnt_t'(exp_credit))
		else log_error($sformatf("num_can_dispatch %0d, model expects %0d",
			num_can_dispatch, exp_credit));
	endfunction

	// one clock of checking, driving and logging what was driven
	task automatic tick();
		@(posedge clock);
		cyc++;
		check_outputs();
		enable <= nxt_en;
		lsq_busy <= nxt_lsq;
		dispatch <= nxt_dispatch;
		inst_in <= nxt_rows;
		cdb <= nxt_cdb;
		record_cycle();
		nxt_dispatch = 1'b0;
		nxt_rows = '0;
		nxt_cdb = '0;
		nxt_num = 0;
	endtask

	task automatic wait_gone(int r, string name);
		int n;
		n = 0;
		while (in_flight[r] && n < wait_limit) begin
			tick();
			n++;
		end
		if (in_flight[r])
			note_failure($sformatf("rob %0d never issued during %s", r, name));
	endtask

	// sweep every tag with queues free until the table is empty
	task automatic drain(string name);
		int n;
		nxt_en = 1'b1;
		nxt_lsq = 2'b00;
		n = 0;
		while (occ != 0 && n < drain_limit) begin
			for (int l = 0; l < ss_size; l++) begin
				nxt_cdb[l].valid = 1'b1;
				nxt_cdb[l].tag = sweep_tag;
				sweep_tag++;
			end
			tick();
			n++;
		end
		if (occ != 0)
			note_failure($sformatf("%0d rows still waiting after %s", occ, name));
		tests++;
		$display("test %s done, %0d errors so far", name, errors);
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic issue_when_ready();
		int r;
		r = queue_row(fu_alu, 6'd1, 1'b1, 6'd2, 1'b1);
		tick();
		wait_gone(r, "single_issue");
		assert (issue_cycle[r] == disp_cycle[r] + 1)
		else log_error($sformatf("ready row took %0d cycles to select",
			issue_cycle[r] - disp_cycle[r]));
		drain("single_issue");
	endtask

	task automatic hold_memory_rows();
		int ld_rob;
		int st_rob;
		nxt_lsq = 2'b11;
		ld_rob = queue_row(fu_ld, 6'd3, 1'b1, 6'd4, 1'b1);
		st_rob = queue_row(fu_st, 6'd5, 1'b1, 6'd6, 1'b1);
		repeat (7) tick();
		assert (in_flight[ld_rob] && in_flight[st_rob])
		else log_error("memory row left while both queues were busy");
		// load queue frees first while the store stays parked
		nxt_lsq = 2'b10;
		wait_gone(ld_rob, "lsq_block");
		assert (in_flight[st_rob]) else log_error("store issued with store queue busy");
		nxt_lsq = 2'b00;
		wait_gone(st_rob, "lsq_block");
		drain("lsq_block");
	endtask

	task automatic fill_until_no_credit();
		int n;
		int k;
		n = 0;
		// rows waiting on tag 63 that only the drain sends
		while (occ < rs_size && n < wait_limit) begin
			k = credit_now();
			for (int j = 0; j < k; j++)
				void'(queue_row(fu_alu, 6'd63, 1'b0, 6'd0, 1'b1));
			tick();
			n++;
		end
		n = 0;
		while (num_can_dispatch != '0 && n < wait_limit) begin
			tick();
			n++;
		end
		assert (num_can_dispatch == '0)
		else log_error("num_can_dispatch did not reach 0 with a full table");
		drain("credit_fill");
	endtask

	task automatic wake_during_stall();
		int r;
		r = queue_row(fu_alu, 6'd40, 1'b0, 6'd0, 1'b1);
		tick();
		nxt_en = 1'b0;
		tick();
		// offered during the stall so it must not be taken
		void'(queue_row(fu_mult, 6'd0, 1'b1, 6'd0, 1'b1));
		nxt_cdb[0].valid = 1'b1;
		nxt_cdb[0].tag = 6'd40;
		repeat (4) tick();
		assert (in_flight[r]) else log_error("row issued during the stall");
		nxt_en = 1'b1;
		wait_gone(r, "stall_wakeup");
		drain("stall_wakeup");
	endtask

	task automatic random_traffic();
		int k;
		logic [1:0] kind;
		phys_reg_t t1;
		phys_reg_t t2;
		logic r1;
		logic r2;
		for (int c = 0; c < random_cycles; c++) begin
			nxt_en = (rand_bits(3) != 0);
			nxt_lsq[lsq_ld_bit] = (rand_bits(2) == 0);
			nxt_lsq[lsq_st_bit] = (rand_bits(2) == 0);
			k = int'(rand_bits(2));
			if (k > credit_now())
				k = credit_now();
			for (int j = 0; j < k; j++) begin
				kind = 2'(rand_bits(2));
				t1 = phys_reg_t'(rand_bits(4));
				r1 = 1'(rand_bits(1));
				t2 = phys_reg_t'(rand_bits(4));
				r2 = 1'(rand_bits(1));
				void'(queue_row(fu_kind_t'(kind), t1, r1, t2, r2));
			end
			for (int l = 0; l < ss_size; l++) begin
				nxt_cdb[l].valid = 1'(rand_bits(1));
				nxt_cdb[l].tag = phys_reg_t'(rand_bits(4));
			end
			tick();
		end
		drain("random");
	endtask

	//////////////////////////////////////////////////
	// sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		enable = 1'b1;
		dispatch = 1'b0;
		inst_in = '0;
		cdb = '0;
		lsq_busy = 2'b00;
		nxt_rows = '0;
		nxt_cdb = '0;
		nxt_dispatch = 1'b0;
		nxt_en = 1'b1;
		nxt_lsq = 2'b00;
		nxt_num = 0;
		lfsr = 32'haa7db3fc;
		sweep_tag = '0;
		for (int i = 0; i < 4; i++)
			en_hist[i] = 1'b1;
		cyc = 8;
		@(posedge clock);
		while (reset)
			@(posedge clock);
		assert (issue == '0 && num_can_dispatch == disp_cnt_t'(ss_size))
		else log_error("outputs not at their reset values");
		tests++;
		$display("test %s done, %0d errors so far", "reset", errors);
		issue_when_ready();
		hold_memory_rows();
		fill_until_no_credit();
		wake_during_stall();
		random_traffic();
		$display("%0d tests, %0d rows issued, %0d errors", tests, issued_total, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* filelist.f */
verilog/rs_pkg.sv
verilog/rs_cam.sv
verilog/rs_issue_select.sv
verilog/rs_compactor.sv
verilog/reservation_station.sv
testbench/rs_clock_gen.sv
testbench/rs_tb.sv

/* Makefile */
# reservation station simulation with verilator
TOP = rs_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
